// ==== bench/cu_kernel_assert.sv ====
// --------------------
// Bound checks for handshake, word order and in-flight limit
// --------------------
`timescale 1ns/1ps

module cu_kernel_assert #(
  parameter int unsigned OUTSTANDING_MAX = cu_pkg::OUTSTANDING_MAX_DEFAULT
) (
  input logic                   ap_clk,
  input logic                   control_areset,
  input cu_pkg::ap_ctrl_in_t    ap_ctrl_in,
  input cu_pkg::ap_ctrl_out_t   ap_ctrl_out,
  input cu_pkg::cu_descriptor_t descriptor,
  input logic                   mem_req_valid,
  input logic                   mem_req_ready,
  input cu_pkg::mem_req_t       mem_req,
  input logic                   cfg_valid,
  input logic                   cfg_ready,
  input cu_pkg::data_t          cfg_data
);
  import cu_pkg::*;

  int             fail_count = 0;
  // Run as the host handed it over
  cu_descriptor_t run;
  count_t         req_idx;
  count_t         out_idx;
  // Request transfers minus output transfers
  int             in_flight;
  wire            req_fire = mem_req_valid && mem_req_ready;
  wire            cfg_fire = cfg_valid && cfg_ready;
  wire            start_ok = ap_ctrl_in.ap_start && ap_ctrl_out.ap_idle;
  // Next expected request address and next expected word address
  wire addr_t     req_addr = run.base + addr_t'(req_idx) * addr_t'(WORD_BYTES);
  wire addr_t     out_addr = run.base + addr_t'(out_idx) * addr_t'(WORD_BYTES);

  task automatic flag_failure(input string msg);
    fail_count++;
    $error("%s", msg);
  endtask

  // --------------------
  // Reference bookkeeping
  // --------------------
  always @(posedge ap_clk) begin
    if (start_ok) begin
      run <= descriptor;
    end
    req_idx   <= start_ok ? '0 : req_idx + count_t'(req_fire);
    out_idx   <= start_ok ? '0 : out_idx + count_t'(cfg_fire);
    in_flight <= control_areset ? 0 : in_flight + int'(req_fire) - int'(cfg_fire);
  end

  // Idle, nothing pending, right out of reset
  assert property (@(posedge ap_clk) $past(control_areset) |->
                   ap_ctrl_out == 3'b001 && !mem_req_valid && !cfg_valid)
    else flag_failure("Outputs not at their reset values after reset");

  // Word i carries its address high and the inverse low
  assert property (@(posedge ap_clk) disable iff (control_areset)
                   cfg_fire |-> cfg_data == {out_addr, ~out_addr})
    else flag_failure($sformatf("Fail cfg_data expected %h got %h",
                                $sampled({out_addr, ~out_addr}), $sampled(cfg_data)));

  assert property (@(posedge ap_clk) disable iff (control_areset)
                   req_fire |-> mem_req.addr == req_addr)
    else flag_failure($sformatf("Fail mem_req.addr expected %h got %h",
                                $sampled(req_addr), $sampled(mem_req.addr)));

  assert property (@(posedge ap_clk) disable iff (control_areset)
                   ap_ctrl_out.ap_done |-> out_idx == run.count)
    else flag_failure($sformatf("Fail words at ap_done expected %h got %h",
                                $sampled(run.count), $sampled(out_idx)));

  // Done one cycle after the last word, or after ap_ready for an empty run
  assert property (@(posedge ap_clk) disable iff (control_areset)
                   (cfg_fire && out_idx == run.count - 1'b1) ||
                   (ap_ctrl_out.ap_ready && run.count == '0) |=> ap_ctrl_out.ap_done)
    else flag_failure("ap_done did not rise on the cycle after the last word");

  assert property (@(posedge ap_clk) disable iff (control_areset)
                   (ap_ctrl_out.ap_done && !ap_ctrl_in.ap_continue |=> ap_ctrl_out.ap_done) and
                   (ap_ctrl_out.ap_done && ap_ctrl_in.ap_continue |=> ap_ctrl_out == 3'b001))
    else flag_failure("ap_done did not hold until ap_continue or did not return to idle");

  // One ap_ready per accepted start, none for a start while busy
  assert property (@(posedge ap_clk) disable iff (control_areset)
                   (start_ok |=> ap_ctrl_out.ap_ready && !ap_ctrl_out.ap_idle) and
                   (ap_ctrl_out.ap_ready |-> $past(start_ok)))
    else flag_failure("ap_ready did not answer exactly the accepted ap_start");

  assert property (@(posedge ap_clk) disable iff (control_areset)
                   in_flight <= int'(OUTSTANDING_MAX))
    else flag_failure($sformatf("Fail in_flight limit %h got %h",
                                OUTSTANDING_MAX, $sampled(in_flight)));

  // Stalled payloads hold
  assert property (@(posedge ap_clk) disable iff (control_areset)
                   (mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req)) and
                   (cfg_valid && !cfg_ready |=> cfg_valid && $stable(cfg_data)) and
                   (ap_ctrl_out.ap_idle |-> !mem_req_valid))
    else flag_failure("Payload moved while stalled or a request was issued while idle");

endmodule : cu_kernel_assert

// Checks ride along with every compute unit top
bind cu_kernel_top cu_kernel_assert #(
  .OUTSTANDING_MAX(OUTSTANDING_MAX)
) u_check (.*);

// ==== bench/tb_cu_kernel.sv ====
// --------------------
// Compute unit testbench with host and memory models
// --------------------
`timescale 1ns/1ps

module tb_cu_kernel;
  import cu_pkg::*;

  logic           ap_clk;
  logic           control_areset;
  ap_ctrl_in_t    ap_ctrl_in;
  ap_ctrl_out_t   ap_ctrl_out;
  cu_descriptor_t descriptor;
  logic           mem_req_valid;
  logic           mem_req_ready = 1'b0;
  mem_req_t       mem_req;
  logic           mem_resp_valid = 1'b0;
  data_t          mem_resp_data = '0;
  logic           cfg_valid;
  logic           cfg_ready = 1'b0;
  data_t          cfg_data;

  // Memory model, responses leave in request order
  addr_t       addr_q[$];
  int          due_q[$];
  int          cycle = 0;
  int          timeouts = 0;
  logic [31:0] lcg_state = 32'h8286bf51;

  // Smaller limit and odd FIFO depth to reach the stall cases
  cu_kernel_top #(.OUTSTANDING_MAX(4), .FIFO_DEPTH(6)) dut0 (.*);

  // Upper LCG bits have the longer period
  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  task automatic next_cycle();
    @(posedge ap_clk);
    #1;
  endtask

  initial begin
    ap_clk = 1'b0;
    forever #50 ap_clk = ~ap_clk;
  end

  // --------------------
  // Memory model
  // --------------------
  // Handshake sampled mid-cycle where both sides are stable
  always @(negedge ap_clk) begin
    if (mem_req_valid && mem_req_ready) begin
      addr_q.push_back(mem_req.addr);
      due_q.push_back(cycle + 1 + int'(next_rand() % 4));
    end
  end

  // Ready levels and read data just after the edge
  always @(posedge ap_clk) begin
    #1;
    cycle++;
    mem_req_ready  = (next_rand() % 4) != 0;
    cfg_ready      = (next_rand() % 2) != 0;
    mem_resp_valid = 1'b0;
    if (due_q.size() > 0 && due_q[0] <= cycle) begin
      mem_resp_valid = 1'b1;
      mem_resp_data  = {addr_q[0], ~addr_q[0]};
      void'(addr_q.pop_front());
      void'(due_q.pop_front());
    end
  end

  // --------------------
  // Host side
  // --------------------
  task automatic wait_for(input logic for_done, input int limit);
    int waited;
    waited = 0;
    while ((for_done ? !ap_ctrl_out.ap_done : !ap_ctrl_out.ap_ready) && waited < limit) begin
      next_cycle();
      waited++;
    end
    if (for_done ? !ap_ctrl_out.ap_done : !ap_ctrl_out.ap_ready) begin
      timeouts++;
      $display("Timeout waiting for %s", for_done ? "ap_done" : "ap_ready");
    end
  endtask

  task automatic run_descriptor(input addr_t base, input count_t count);
    next_cycle();
    descriptor = '{base: base, count: count};
    ap_ctrl_in.ap_start = 1'b1;
    wait_for(1'b0, 20);
    ap_ctrl_in.ap_start = 1'b0;
    // Stray start while busy
    descriptor = '{base: ~base, count: count + 16'd3};
    next_cycle();
    ap_ctrl_in.ap_start = 1'b1;
    next_cycle();
    ap_ctrl_in.ap_start = 1'b0;
    wait_for(1'b1, 2000);
    ap_ctrl_in.ap_continue = 1'b1;
    next_cycle();
    ap_ctrl_in.ap_continue = 1'b0;
  endtask

  initial begin
    control_areset = 1'b1;
    ap_ctrl_in     = '0;
    descriptor     = '0;
    repeat (4) @(posedge ap_clk);
    #1;
    control_areset = 1'b0;
    run_descriptor(32'h0000_1000, 16'd0);
    run_descriptor(32'h0004_0a08, 16'd5);
    run_descriptor(32'h8000_ff00, 16'd40);
    // Let the last implications settle
    repeat (4) @(posedge ap_clk);
    $display("Checks done: %0d assertion failures, %0d timeouts",
             dut0.u_check.fail_count, timeouts);
    if (dut0.u_check.fail_count == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule : tb_cu_kernel

// ==== files.f ====
hdl/cu_pkg.sv
hdl/cu_kernel_control.sv
hdl/cu_setup_request.sv
hdl/cu_response_fifo.sv
hdl/cu_kernel_top.sv
bench/cu_kernel_assert.sv
bench/tb_cu_kernel.sv

// ==== hdl/cu_kernel_control.sv ====
// --------------------
// ap_ctrl_chain FSM with descriptor capture
// Counts delivered words to decide when the run is done
// --------------------
`timescale 1ns/1ps

module cu_kernel_control (
  input  logic                   ap_clk,
  input  logic                   control_areset,
  input  cu_pkg::ap_ctrl_in_t    ap_ctrl_in,
  input  cu_pkg::cu_descriptor_t descriptor,
  input  logic                   word_pop,
  output cu_pkg::ap_ctrl_out_t   ap_ctrl_out,
  output logic                   run_start,
  output cu_pkg::cu_descriptor_t run_desc
);
  import cu_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_next;

  // Words already handed to the consumer in this run
  count_t pop_count;
  count_t pop_count_next;

  // Registered one-cycle ap_ready
  logic ready_pulse;

  // Start accepted only from idle
  logic start_seen;

  // Last word leaves this cycle, or nothing to deliver at all
  logic run_last;

  assign start_seen     = (state == CTRL_IDLE) && ap_ctrl_in.ap_start;
  assign pop_count_next = pop_count + count_t'(word_pop);
  assign run_last       = (pop_count_next == run_desc.count);

  // --------------------
  // Next state
  // --------------------
  always_comb begin
    state_next = state;
    case (state)
      CTRL_IDLE: begin
        if (start_seen) begin
          state_next = CTRL_RUN;
        end
      end
      CTRL_RUN: begin
        // Zero count falls through here on the ap_ready cycle
        if (run_last) begin
          state_next = CTRL_DONE;
        end
      end
      CTRL_DONE: begin
        // Host acknowledges, back to idle
        if (ap_ctrl_in.ap_continue) begin
          state_next = CTRL_IDLE;
        end
      end
      default: begin
        state_next = CTRL_IDLE;
      end
    endcase
  end

  // --------------------
  // State and pulses
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      state       <= CTRL_IDLE;
      ready_pulse <= 1'b0;
      run_start   <= 1'b0;
      pop_count   <= '0;
    end else begin
      state       <= state_next;
      ready_pulse <= start_seen;
      run_start   <= start_seen;
      if (start_seen) begin
        pop_count <= '0;
      end else if (state == CTRL_RUN) begin
        pop_count <= pop_count_next;
      end
    end
  end

  // Descriptor held for the whole run
  always_ff @(posedge ap_clk) begin
    if (start_seen) begin
      run_desc <= descriptor;
    end
  end

  // Idle and done come straight from the state
  assign ap_ctrl_out.ap_ready = ready_pulse;
  assign ap_ctrl_out.ap_done  = (state == CTRL_DONE);
  assign ap_ctrl_out.ap_idle  = (state == CTRL_IDLE);

endmodule : cu_kernel_control

// ==== hdl/cu_kernel_top.sv ====
// --------------------
// Compute unit top, control and config read path
// --------------------
`timescale 1ns/1ps

module cu_kernel_top #(
  parameter int unsigned OUTSTANDING_MAX = cu_pkg::OUTSTANDING_MAX_DEFAULT,
  parameter int unsigned FIFO_DEPTH      = cu_pkg::FIFO_DEPTH_DEFAULT
) (
  input  logic                   ap_clk,
  input  logic                   control_areset,
  // Host control and descriptor
  input  cu_pkg::ap_ctrl_in_t    ap_ctrl_in,
  output cu_pkg::ap_ctrl_out_t   ap_ctrl_out,
  input  cu_pkg::cu_descriptor_t descriptor,
  // Memory read requests
  output logic                   mem_req_valid,
  input  logic                   mem_req_ready,
  output cu_pkg::mem_req_t       mem_req,
  // Memory read data, in order
  input  logic                   mem_resp_valid,
  input  cu_pkg::data_t          mem_resp_data,
  // Config word stream
  output logic                   cfg_valid,
  input  logic                   cfg_ready,
  output cu_pkg::data_t          cfg_data
);
  import cu_pkg::*;

  // Control to request walker
  logic           run_start;
  cu_descriptor_t run_desc;

  // Output transfer, shared by control and walker
  logic word_pop;

  // --------------------
  // Control FSM
  // --------------------
  cu_kernel_control u_control (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .ap_ctrl_in    (ap_ctrl_in),
    .descriptor    (descriptor),
    .word_pop      (word_pop),
    .ap_ctrl_out   (ap_ctrl_out),
    .run_start     (run_start),
    .run_desc      (run_desc)
  );

  // --------------------
  // Request walker
  // --------------------
  cu_setup_request #(
    .OUTSTANDING_MAX(OUTSTANDING_MAX)
  ) u_setup_request (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .run_start     (run_start),
    .run_desc      (run_desc),
    .mem_req_ready (mem_req_ready),
    .word_pop      (word_pop),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req)
  );

  // --------------------
  // Response buffer
  // --------------------
  cu_response_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_response_fifo (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .mem_resp_valid(mem_resp_valid),
    .mem_resp_data (mem_resp_data),
    .cfg_ready     (cfg_ready),
    .cfg_valid     (cfg_valid),
    .cfg_data      (cfg_data),
    .word_pop      (word_pop)
  );

endmodule : cu_kernel_top

// ==== hdl/cu_pkg.sv ====
// --------------------
// Compute unit shared types
// Widths, bundles, control states and default sizing
// --------------------
package cu_pkg;

  // --------------------
  // Widths with a meaning
  // --------------------

  // Byte address into configuration memory
  typedef logic [31:0] addr_t;

  // One configuration word
  typedef logic [63:0] data_t;

  // Word count and word index
  typedef logic [15:0] count_t;

  // Byte stride between consecutive 64-bit words
  localparam int unsigned WORD_BYTES = 8;

  // --------------------
  // Bundles
  // --------------------

  // Host descriptor, base first
  typedef struct packed {
    addr_t  base;
    count_t count;
  } cu_descriptor_t;

  // ap_ctrl_chain inputs from the host
  typedef struct packed {
    logic ap_start;
    logic ap_continue;
  } ap_ctrl_in_t;

  // ap_ctrl_chain outputs to the host
  typedef struct packed {
    logic ap_ready;
    logic ap_done;
    logic ap_idle;
  } ap_ctrl_out_t;

  // Memory read request, room for more fields later
  typedef struct packed {
    addr_t addr;
  } mem_req_t;

  // Control FSM states
  typedef enum logic [1:0] {
    CTRL_IDLE = 2'd0,
    CTRL_RUN  = 2'd1,
    CTRL_DONE = 2'd2
  } ctrl_state_e;

  // Default sizing, FIFO must be at least as deep as the request limit
  localparam int unsigned OUTSTANDING_MAX_DEFAULT = 8;
  localparam int unsigned FIFO_DEPTH_DEFAULT      = 8;

endpackage : cu_pkg

// ==== hdl/cu_response_fifo.sv ====
// --------------------
// Response FIFO
// Buffers read data and drains it to the config stream
// --------------------
`timescale 1ns/1ps

module cu_response_fifo #(
  parameter int unsigned FIFO_DEPTH = cu_pkg::FIFO_DEPTH_DEFAULT
) (
  input  logic          ap_clk,
  input  logic          control_areset,
  input  logic          mem_resp_valid,
  input  cu_pkg::data_t mem_resp_data,
  input  logic          cfg_ready,
  output logic          cfg_valid,
  output cu_pkg::data_t cfg_data,
  output logic          word_pop
);
  import cu_pkg::*;

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned OCC_W = $clog2(FIFO_DEPTH + 1);

  data_t mem [0:FIFO_DEPTH-1];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [OCC_W-1:0] occupancy;

  // Wrap at the depth, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Head word, valid one cycle after its write at the earliest
  assign cfg_valid = (occupancy != '0);
  assign cfg_data  = mem[rd_ptr];
  assign word_pop  = cfg_valid && cfg_ready;

  // --------------------
  // Storage
  // --------------------
  // No full check, the request limit keeps room for every response
  always_ff @(posedge ap_clk) begin
    if (mem_resp_valid) begin
      mem[wr_ptr] <= mem_resp_data;
    end
  end

  // --------------------
  // Pointers and occupancy
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occupancy <= '0;
    end else begin
      if (mem_resp_valid) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (word_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({mem_resp_valid, word_pop})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;
      endcase
    end
  end

endmodule : cu_response_fifo

// ==== hdl/cu_setup_request.sv ====
// --------------------
// Setup reader request walker
// Issues one read per word under an in-flight limit
// --------------------
`timescale 1ns/1ps

module cu_setup_request #(
  parameter int unsigned OUTSTANDING_MAX = cu_pkg::OUTSTANDING_MAX_DEFAULT
) (
  input  logic                   ap_clk,
  input  logic                   control_areset,
  input  logic                   run_start,
  input  cu_pkg::cu_descriptor_t run_desc,
  input  logic                   mem_req_ready,
  input  logic                   word_pop,
  output logic                   mem_req_valid,
  output cu_pkg::mem_req_t       mem_req
);
  import cu_pkg::*;

  localparam int unsigned FLIGHT_W = $clog2(OUTSTANDING_MAX + 1);

  // Requests still to issue in this run
  count_t req_left;

  // Issued but not yet popped at the output
  logic [FLIGHT_W-1:0] in_flight;

  // Address of the request on the bus
  addr_t req_addr;

  logic req_fire;
  logic at_limit;

  assign at_limit = (in_flight == FLIGHT_W'(OUTSTANDING_MAX));

  // Counter only grows on a handshake, so valid never drops before it
  assign mem_req_valid = (req_left != '0) && !at_limit;
  assign req_fire      = mem_req_valid && mem_req_ready;

  // --------------------
  // Issue and in-flight counters
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      req_left  <= '0;
      in_flight <= '0;
    end else begin
      if (run_start) begin
        req_left <= run_desc.count;
      end else if (req_fire) begin
        req_left <= req_left - 1'b1;
      end

      // Up on request transfer, down on word leaving the unit
      case ({req_fire, word_pop})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

  // Address walk, held while the bus stalls
  always_ff @(posedge ap_clk) begin
    if (run_start) begin
      req_addr <= run_desc.base;
    end else if (req_fire) begin
      req_addr <= req_addr + addr_t'(WORD_BYTES);
    end
  end

  always_comb begin
    mem_req      = '0;
    mem_req.addr = req_addr;
  end

endmodule : cu_setup_request
